// File: compile.f
rtl/oflow_pkg.sv
rtl/oflow_mem.sv
rtl/oflow_region_ctrl.sv
rtl/oflow_mem_buffer.sv
rtl/oflow_mem_arbiter.sv
rtl/oflow_feature_writer.sv
rtl/oflow_history_reader.sv
rtl/oflow_history_top.sv
verif/tb_checker.sv
verif/tb_top.sv

// File: verif/tb_top.sv
module tb_top import oflow_pkg::*; ();

	// Pairs written per frame and fetches per group
	localparam int PAIRS     = 4;
	localparam int READS     = 4;
	// Strobe slots that carry a write and a fetch together in the contention test
	localparam int CONTEND   = 8;
	// Rough cycle cost of one frame (start, strobes every other cycle, drain) and of one fetch group
	localparam int FRAME_LEN = 2 * 2 + PAIRS * 2 + 4;
	localparam int FETCH_LEN = READS * 2 + 4;
	// Length of each test in cycles as its frames and fetch groups times their cost
	localparam int LEN_T1    = 2 * (FRAME_LEN + FETCH_LEN);
	localparam int LEN_T2    = 14 * FRAME_LEN + 4 * FETCH_LEN;
	localparam int LEN_T3    = 7 * FRAME_LEN + FETCH_LEN;
	localparam int LEN_T4    = 5 * FRAME_LEN + CONTEND * 2 + 4;
	localparam int LEN_T5    = 6 * FRAME_LEN + 2 * FETCH_LEN;
	localparam int CYCLE_LIMIT = (10 + LEN_T1 + LEN_T2 + LEN_T3 + LEN_T4 + LEN_T5) * 4;

	logic                         clk;
	logic                         reset_N;
	logic                         frame_start;
	logic [FRAME_WIDTH-1:0]       frame_num;
	logic [HIST_WIDTH-1:0]        num_of_history_frames;
	logic                         feat_valid;
	feature_pair_t                feat;
	logic                         fetch_valid;
	logic [HIST_WIDTH-1:0]        fetch_back;
	logic [1:0][OFFSET_WIDTH-1:0] fetch_offsets;
	logic                         hist_valid;
	logic [DATA_WIDTH-1:0]        hist_data_0;
	logic [DATA_WIDTH-1:0]        hist_data_1;
	logic                         wr_busy;
	logic                         wr_full;
	logic                         rd_full;

	// Shadow memory, latched region count and current frame of the reference model
	logic [DATA_WIDTH-1:0] shadow [MEM_DEPTH];
	logic [31:0]           rng_state;
	int                    model_n;
	int                    model_frame;
	// Offsets written into each slot by its newest frame so that reads only hit written words
	int                    slot_cnt [MAX_HIST];
	int                    slot_offs [MAX_HIST][2*CONTEND];
	int                    cycle_count;

	oflow_history_top #(.FIFO_DEPTH(4)) dut (
		.clk (clk), .reset_N (reset_N),
		.frame_start (frame_start), .frame_num (frame_num),
		.num_of_history_frames (num_of_history_frames),
		.feat_valid (feat_valid), .feat (feat),
		.fetch_valid (fetch_valid), .fetch_back (fetch_back), .fetch_offsets (fetch_offsets),
		.hist_valid (hist_valid), .hist_data_0 (hist_data_0), .hist_data_1 (hist_data_1),
		.wr_busy (wr_busy), .wr_full (wr_full), .rd_full (rd_full)
	);

	tb_checker u_checker (
		.clk (clk), .reset_N (reset_N), .hist_valid (hist_valid),
		.hist_data_0 (hist_data_0), .hist_data_1 (hist_data_1),
		.wr_busy (wr_busy), .wr_full (wr_full), .rd_full (rd_full)
	);

	always #10 clk = ~clk;

	// The cycle limit scales with the test lengths above
	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= CYCLE_LIMIT) begin
			$display("Timeout: the run passed %0d cycles without finishing", CYCLE_LIMIT);
			$display("TEST FAILED");
			$finish;
		end
	end

	// 32-bit xorshift generator
	function automatic logic [31:0] next_rand();
		rng_state = rng_state ^ (rng_state << 13);
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return rng_state;
	endfunction

	// Frame f sits in region f mod N, whose base is that slot times floor(128 / N)
	// A write updates the shadow words, and either access returns the pair now stored there
	function automatic logic [2*DATA_WIDTH-1:0] model_access(input logic we, input int frame,
			input int off0, input int off1, input logic [15:0] d0, input logic [15:0] d1);
		int base;
		base = (frame % model_n) * (MEM_DEPTH / model_n);
		if (we) begin
			shadow[base + off0] = d0;
			shadow[base + off1] = d1;
		end
		return {shadow[base + off0], shadow[base + off1]};
	endfunction

	// Pick a random pair with two distinct offsets inside the current region size
	task automatic load_feat();
		int            size;
		int            slot;
		int            o0;
		int            o1;
		feature_pair_t pair;
		size = MEM_DEPTH / model_n;
		o0 = next_rand() % size;
		o1 = (o0 + 1 + next_rand() % (size - 1)) % size;
		pair.data_0 = 16'(next_rand());
		pair.data_1 = 16'(next_rand());
		pair.offset_0 = 7'(o0);
		pair.offset_1 = 7'(o1);
		void'(model_access(1'b1, model_frame, o0, o1, pair.data_0, pair.data_1));
		slot = model_frame % model_n;
		slot_offs[slot][slot_cnt[slot]] = o0;
		slot_offs[slot][slot_cnt[slot] + 1] = o1;
		slot_cnt[slot] = slot_cnt[slot] + 2;
		feat <= pair;
		feat_valid <= 1'b1;
	endtask

	// Fetch two offsets that the target frame wrote, and queue the predicted pair
	task automatic load_fetch(input int back);
		int frame;
		int slot;
		int o0;
		int o1;
		frame = (model_frame - back + 256) % 256;
		slot = frame % model_n;
		o0 = slot_offs[slot][next_rand() % slot_cnt[slot]];
		o1 = slot_offs[slot][next_rand() % slot_cnt[slot]];
		u_checker.expect_pair(model_access(1'b0, frame, o0, o1, 16'h0, 16'h0));
		fetch_back <= HIST_WIDTH'(back);
		fetch_offsets <= {7'(o1), 7'(o0)};
		fetch_valid <= 1'b1;
	endtask

	// One strobe slot lasts two cycles so the full flags seen next are settled
	task automatic issue(input bit do_write, input bit do_fetch, input int back);
		while ((do_write && wr_full) || (do_fetch && rd_full))
			@(posedge clk);
		if (do_write)
			load_feat();
		if (do_fetch)
			load_fetch(back);
		@(posedge clk);
		feat_valid <= 1'b0;
		fetch_valid <= 1'b0;
		@(posedge clk);
	endtask

	// Wait for the writer to empty and for every fetch to return
	task automatic wait_idle();
		while (wr_busy || u_checker.pending() != 0)
			@(posedge clk);
	endtask

	// The count only takes effect at frame 0 and other frames keep the old layout
	task automatic start_frame(input int frame, input int n);
		frame_start <= 1'b1;
		frame_num <= FRAME_WIDTH'(frame);
		num_of_history_frames <= HIST_WIDTH'(n);
		model_frame = frame;
		if (frame == 0) begin
			model_n = n;
			foreach (slot_cnt[i])
				slot_cnt[i] = 0;
		end
		slot_cnt[frame % model_n] = 0;
		@(posedge clk);
		frame_start <= 1'b0;
		@(posedge clk);
	endtask

	task automatic fill_frames(input int n, input int first, input int count);
		for (int f = first; f < first + count; f++) begin
			start_frame(f, n);
			repeat (PAIRS)
				issue(1'b1, 1'b0, 0);
			wait_idle();
		end
	endtask

	// Sweep fetch_back across back_lo to back_hi
	task automatic fetch_some(input int count, input int back_lo, input int back_hi);
		for (int i = 0; i < count; i++)
			issue(1'b0, 1'b1, back_lo + i % (back_hi - back_lo + 1));
		wait_idle();
	endtask

	initial begin
		clk = 1'b0;
		reset_N = 1'b0;
		frame_start = 1'b0;
		frame_num = '0;
		num_of_history_frames = HIST_WIDTH'(1);
		feat_valid = 1'b0;
		feat = '0;
		fetch_valid = 1'b0;
		fetch_back = '0;
		fetch_offsets = '0;
		rng_state = 32'd8272;
		model_n = 1;
		model_frame = 0;
		cycle_count = 0;
		repeat (10)
			@(posedge clk);
		reset_N <= 1'b1;
		@(posedge clk);
		u_checker.check_idle();

		// Single region with frame 0 and then frame 1 read back at distance 0
		fill_frames(1, 0, 1);
		fetch_some(READS, 0, 0);
		fill_frames(1, 1, 1);
		fetch_some(READS, 0, 0);
		u_checker.end_test("single region");

		for (int n = 2; n <= MAX_HIST; n++) begin
			fill_frames(n, 0, n);
			fetch_some(READS, 1, n - 1);
		end
		u_checker.end_test("region bases");

		// Frames 3 to 6 reuse slots and the newest writer of a slot must win
		fill_frames(3, 0, 7);
		fetch_some(READS, 1, 2);
		u_checker.end_test("region wrap");

		// Frame 4 writes slot 4 while fetches read slots 0 to 3 in the same cycles
		fill_frames(5, 0, 4);
		start_frame(4, 5);
		for (int i = 0; i < CONTEND; i++)
			issue(1'b1, 1'b1, 1 + i % 4);
		wait_idle();
		u_checker.end_test("contention");

		// A count at frame 3 is ignored while a count at frame 0 changes the layout
		fill_frames(3, 0, 3);
		fill_frames(5, 3, 1);
		fetch_some(READS, 1, 2);
		fill_frames(2, 0, 2);
		fetch_some(READS, 1, 1);
		u_checker.end_test("reconfiguration");

		u_checker.final_report();
		if (u_checker.error_count == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

// File: verif/tb_checker.sv
module tb_checker import oflow_pkg::*; (
	input logic                  clk,
	input logic                  reset_N,
	input logic                  hist_valid,
	input logic [DATA_WIDTH-1:0] hist_data_0,
	input logic [DATA_WIDTH-1:0] hist_data_1,
	input logic                  wr_busy,
	input logic                  wr_full,
	input logic                  rd_full
);

	// Predicted pairs in fetch order, upper word is hist_data_0
	logic [2*DATA_WIDTH-1:0] expected_q [$];
	logic [2*DATA_WIDTH-1:0] want;
	int                      error_count = 0;
	int                      check_count = 0;
	int                      test_checks = 0;
	int                      test_errors = 0;
	int                      tests_done = 0;

	task automatic expect_pair(input logic [2*DATA_WIDTH-1:0] pair);
		expected_q.push_back(pair);
	endtask

	function automatic int pending();
		return expected_q.size();
	endfunction

	task automatic compare_word(input string name, input logic [DATA_WIDTH-1:0] got,
			input logic [DATA_WIDTH-1:0] exp_val);
		check_count++;
		test_checks++;
		if (got !== exp_val) begin
			$display("[ERROR] %s got 0x%h expected 0x%h", name, got, exp_val);
			error_count++;
			test_errors++;
		end
	endtask

	// Status outputs must all be low straight after reset
	task automatic check_idle();
		compare_word("hist_valid", DATA_WIDTH'(hist_valid), '0);
		compare_word("wr_busy", DATA_WIDTH'(wr_busy), '0);
		compare_word("wr_full", DATA_WIDTH'(wr_full), '0);
		compare_word("rd_full", DATA_WIDTH'(rd_full), '0);
	endtask

	// The falling edge sits mid-cycle, where the read data and its flag are steady
	always @(negedge clk) begin
		if (reset_N && hist_valid) begin
			if (expected_q.size() == 0) begin
				$display("hist_valid pulsed while no fetch was outstanding");
				error_count++;
				test_errors++;
			end else begin
				want = expected_q.pop_front();
				compare_word("hist_data_0", hist_data_0, want[2*DATA_WIDTH-1:DATA_WIDTH]);
				compare_word("hist_data_1", hist_data_1, want[DATA_WIDTH-1:0]);
			end
		end
	end

	task automatic end_test(input string name);
		$display("%s: %0d checks, %0d errors", name, test_checks, test_errors);
		tests_done++;
		test_checks = 0;
		test_errors = 0;
	endtask

	// Fetches still queued here never produced a hist_valid
	task automatic final_report();
		if (expected_q.size() != 0) begin
			$display("%0d fetches never returned any data", expected_q.size());
			error_count += expected_q.size();
		end
		$display("summary: %0d tests, %0d checks, %0d errors", tests_done, check_count,
			error_count);
	endtask

endmodule

// File: rtl/oflow_history_top.sv
module oflow_history_top import oflow_pkg::*; #(
	parameter int FIFO_DEPTH = 4
) (
	input  logic                         clk,
	input  logic                         reset_N,
	input  logic                         frame_start,
	input  logic [FRAME_WIDTH-1:0]       frame_num,
	input  logic [HIST_WIDTH-1:0]        num_of_history_frames,
	input  logic                         feat_valid,
	input  feature_pair_t                feat,
	input  logic                         fetch_valid,
	input  logic [HIST_WIDTH-1:0]        fetch_back,
	input  logic [1:0][OFFSET_WIDTH-1:0] fetch_offsets,
	output logic                         hist_valid,
	output logic [DATA_WIDTH-1:0]        hist_data_0,
	output logic [DATA_WIDTH-1:0]        hist_data_1,
	output logic                         wr_busy,
	output logic                         wr_full,
	output logic                         rd_full
);

	// Peer requests and grants
	logic     wr_req;
	logic     rd_req;
	logic     wr_gnt;
	logic     rd_gnt;
	mem_req_t wr_cmd;
	mem_req_t rd_cmd;

	// Granted request and the layout that applies to it
	mem_req_t                req;
	logic                    req_valid;
	logic [ADDR_WIDTH-1:0]   base_addr;
	logic [FRAME_WIDTH-1:0]  cur_frame;
	logic [HIST_WIDTH-1:0]   num_hist;
	logic [DATA_WIDTH-1:0]   mem_data_0;
	logic [DATA_WIDTH-1:0]   mem_data_1;

	oflow_feature_writer #(.FIFO_DEPTH(FIFO_DEPTH)) u_writer (
		.clk (clk), .reset_N (reset_N),
		.feat_valid (feat_valid), .feat (feat), .cur_frame (cur_frame),
		.gnt (wr_gnt), .req (wr_req), .cmd (wr_cmd),
		.busy (wr_busy), .full (wr_full)
	);

	oflow_history_reader #(.FIFO_DEPTH(FIFO_DEPTH)) u_reader (
		.clk (clk), .reset_N (reset_N),
		.fetch_valid (fetch_valid), .fetch_back (fetch_back),
		.fetch_offsets (fetch_offsets), .cur_frame (cur_frame),
		.gnt (rd_gnt), .mem_data_0 (mem_data_0), .mem_data_1 (mem_data_1),
		.req (rd_req), .cmd (rd_cmd), .full (rd_full),
		.hist_valid (hist_valid), .hist_data_0 (hist_data_0), .hist_data_1 (hist_data_1)
	);

	oflow_mem_arbiter u_arbiter (
		.clk (clk), .reset_N (reset_N),
		.wr_req (wr_req), .rd_req (rd_req), .wr_cmd (wr_cmd), .rd_cmd (rd_cmd),
		.wr_gnt (wr_gnt), .rd_gnt (rd_gnt), .req (req), .req_valid (req_valid)
	);

	// Base follows the frame of whatever request won this cycle
	oflow_region_ctrl u_region_ctrl (
		.clk (clk), .reset_N (reset_N),
		.frame_start (frame_start), .frame_num (frame_num),
		.num_of_history_frames (num_of_history_frames), .frame_sel (req.frame_sel),
		.base_addr (base_addr), .cur_frame (cur_frame), .num_hist (num_hist)
	);

	oflow_mem_buffer u_buffer (
		.clk (clk), .reset_N (reset_N),
		.req (req), .req_valid (req_valid), .base_addr (base_addr), .num_hist (num_hist),
		.data_out_0 (mem_data_0), .data_out_1 (mem_data_1)
	);

endmodule

// File: rtl/oflow_history_reader.sv
module oflow_history_reader import oflow_pkg::*; #(
	parameter int FIFO_DEPTH = 4
) (
	input  logic                               clk,
	input  logic                               reset_N,
	input  logic                               fetch_valid,
	input  logic [HIST_WIDTH-1:0]              fetch_back,
	input  logic [1:0][OFFSET_WIDTH-1:0]       fetch_offsets,
	input  logic [FRAME_WIDTH-1:0]             cur_frame,
	input  logic                               gnt,
	input  logic [DATA_WIDTH-1:0]              mem_data_0,
	input  logic [DATA_WIDTH-1:0]              mem_data_1,
	output logic                               req,
	output mem_req_t                           cmd,
	output logic                               full,
	output logic                               hist_valid,
	output logic [DATA_WIDTH-1:0]              hist_data_0,
	output logic [DATA_WIDTH-1:0]              hist_data_1
);

	localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
	localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

	mem_req_t         fifo [FIFO_DEPTH];
	mem_req_t         new_cmd;
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic             push;
	logic             read_pending;

	// The past frame is resolved at enqueue time, wrapping at 256
	always_comb begin
		new_cmd                = '0;
		new_cmd.we             = 1'b0;
		new_cmd.frame_sel      = FRAME_WIDTH'(cur_frame - fetch_back);
		new_cmd.pair.offset_0  = fetch_offsets[0];
		new_cmd.pair.offset_1  = fetch_offsets[1];
	end

	assign push = fetch_valid && !full;

	always_ff @(posedge clk) begin
		if (push)
			fifo[wr_ptr] <= new_cmd;
	end

	always_ff @(posedge clk) begin
		if (!reset_N) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push)
				wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (gnt)
				rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			if (push && !gnt)
				count <= count + 1'b1;
			else if (gnt && !push)
				count <= count - 1'b1;
		end
	end

	// Memory output registers load at the grant edge
	// so the data is ready one cycle after the grant
	always_ff @(posedge clk) begin
		if (!reset_N)
			read_pending <= 1'b0;
		else
			read_pending <= gnt;
	end

	assign req         = (count != '0);
	assign cmd         = fifo[rd_ptr];
	assign full        = (count == CNT_W'(FIFO_DEPTH));
	assign hist_valid  = read_pending;
	assign hist_data_0 = mem_data_0;
	assign hist_data_1 = mem_data_1;

endmodule

// File: rtl/oflow_feature_writer.sv
module oflow_feature_writer import oflow_pkg::*; #(
	parameter int FIFO_DEPTH = 4
) (
	input  logic                   clk,
	input  logic                   reset_N,
	input  logic                   feat_valid,
	input  feature_pair_t          feat,
	input  logic [FRAME_WIDTH-1:0] cur_frame,
	input  logic                   gnt,
	output logic                   req,
	output mem_req_t               cmd,
	output logic                   busy,
	output logic                   full
);

	localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
	localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

	feature_pair_t    fifo [FIFO_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic             push;
	logic             pop;

	// Strobes arriving while full are dropped
	assign push = feat_valid && !full;
	// The head leaves in the same cycle it is granted
	assign pop  = gnt;

	// Storage only holds payload
	always_ff @(posedge clk) begin
		if (push)
			fifo[wr_ptr] <= feat;
	end

	always_ff @(posedge clk) begin
		if (!reset_N) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push)
				wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			if (push && !pop)
				count <= count + 1'b1;
			else if (pop && !push)
				count <= count - 1'b1;
		end
	end

	// Pairs are tagged with the frame current at issue time
	always_comb begin
		cmd           = '0;
		cmd.we        = 1'b1;
		cmd.frame_sel = cur_frame;
		cmd.pair      = fifo[rd_ptr];
	end

	assign req  = (count != '0);
	assign busy = (count != '0);
	assign full = (count == CNT_W'(FIFO_DEPTH));

endmodule

// File: rtl/oflow_mem_arbiter.sv
module oflow_mem_arbiter import oflow_pkg::*; (
	input  logic     clk,
	input  logic     reset_N,
	input  logic     wr_req,
	input  logic     rd_req,
	input  mem_req_t wr_cmd,
	input  mem_req_t rd_cmd,
	output logic     wr_gnt,
	output logic     rd_gnt,
	output mem_req_t req,
	output logic     req_valid
);

	arb_state_t pref;

	// A lone requester is granted at once
	// On a tie the preferred peer wins
	assign wr_gnt = wr_req && (!rd_req || pref == PREFER_WRITER);
	assign rd_gnt = rd_req && (!wr_req || pref == PREFER_READER);

	// Forward whichever command won this cycle
	assign req_valid = wr_gnt || rd_gnt;
	assign req       = rd_gnt ? rd_cmd : wr_cmd;

	// Flip the preference after each tie so two busy peers alternate
	always_ff @(posedge clk) begin
		if (!reset_N) begin
			pref <= PREFER_WRITER;
		end else if (wr_req && rd_req) begin
			pref <= (pref == PREFER_WRITER) ? PREFER_READER : PREFER_WRITER;
		end
	end

	// A peer that lost a tie owns the flipped preference and wins the next cycle
	a_wr_turn: assert property (@(posedge clk) disable iff (!reset_N)
		(wr_req && !wr_gnt) |=> wr_gnt);
	a_rd_turn: assert property (@(posedge clk) disable iff (!reset_N)
		(rd_req && !rd_gnt) |=> rd_gnt);

	// A peer that lost arbitration must still be asking next cycle
	a_wr_hold: assert property (@(posedge clk) disable iff (!reset_N)
		(wr_req && !wr_gnt) |=> wr_req);
	a_rd_hold: assert property (@(posedge clk) disable iff (!reset_N)
		(rd_req && !rd_gnt) |=> rd_req);

endmodule

// File: rtl/oflow_mem_buffer.sv
module oflow_mem_buffer import oflow_pkg::*; (
	input  logic                  clk,
	input  logic                  reset_N,
	input  mem_req_t              req,
	input  logic                  req_valid,
	input  logic [ADDR_WIDTH-1:0] base_addr,
	input  logic [HIST_WIDTH-1:0] num_hist,
	output logic [DATA_WIDTH-1:0] data_out_0,
	output logic [DATA_WIDTH-1:0] data_out_1
);

	// Physical addresses and strobes for the two memory ports
	logic [ADDR_WIDTH-1:0] addr_0;
	logic [ADDR_WIDTH-1:0] addr_1;
	logic                  we;
	logic                  oe;

	// Offsets are relative to the region of the requested frame
	assign addr_0 = base_addr + req.pair.offset_0;
	assign addr_1 = base_addr + req.pair.offset_1;

	// A granted request is either a write of both words or a read of both
	assign we = req_valid && req.we;
	assign oe = req_valid && !req.we;

	oflow_mem u_mem (
		.clk        (clk),
		.reset_N    (reset_N),
		.address_0  (addr_0),
		.address_1  (addr_1),
		.data_in_0  (req.pair.data_0),
		.data_in_1  (req.pair.data_1),
		.we_0       (we),
		.we_1       (we),
		.oe_0       (oe),
		.oe_1       (oe),
		.data_out_0 (data_out_0),
		.data_out_1 (data_out_1)
	);

	// An offset past the region end would corrupt the neighbouring frame
	a_offset_in_region: assert property (@(posedge clk) disable iff (!reset_N)
		req_valid |-> ((ADDR_WIDTH+1)'(req.pair.offset_0) < region_size(num_hist)
			&& (ADDR_WIDTH+1)'(req.pair.offset_1) < region_size(num_hist)));

endmodule

// File: rtl/oflow_region_ctrl.sv
module oflow_region_ctrl import oflow_pkg::*; (
	input  logic                   clk,
	input  logic                   reset_N,
	input  logic                   frame_start,
	input  logic [FRAME_WIDTH-1:0] frame_num,
	input  logic [HIST_WIDTH-1:0]  num_of_history_frames,
	input  logic [FRAME_WIDTH-1:0] frame_sel,
	output logic [ADDR_WIDTH-1:0]  base_addr,
	output logic [FRAME_WIDTH-1:0] cur_frame,
	output logic [HIST_WIDTH-1:0]  num_hist
);

	// Region slot of the selected frame and its full-width base product
	logic [HIST_WIDTH-1:0]            slot;
	logic [HIST_WIDTH+ADDR_WIDTH:0]   base_prod;

	// The layout only changes when a new sequence begins at frame 0
	always_ff @(posedge clk) begin
		if (!reset_N) begin
			num_hist <= HIST_WIDTH'(1);
		end else if (frame_start && frame_num == '0) begin
			num_hist <= num_of_history_frames;
		end
	end

	// Every frame start moves the writer on to the new frame
	always_ff @(posedge clk) begin
		if (!reset_N) begin
			cur_frame <= '0;
		end else if (frame_start) begin
			cur_frame <= frame_num;
		end
	end

	// Frame f lives in region f mod N
	assign slot = HIST_WIDTH'(frame_sel % num_hist);

	// Base is slot times the region size from the five-entry size table
	// With N of 1 the slot is always 0 so the 128 entry never reaches the address
	assign base_prod = slot * region_size(num_hist);
	assign base_addr = base_prod[ADDR_WIDTH-1:0];

	// A zero or oversized count would break the region arithmetic
	a_num_hist_legal: assert property (@(posedge clk) disable iff (!reset_N)
		num_hist >= HIST_WIDTH'(1) && num_hist <= HIST_WIDTH'(MAX_HIST));

endmodule

// File: rtl/oflow_mem.sv
module oflow_mem import oflow_pkg::*; (
	input  logic                  clk,
	input  logic                  reset_N,
	input  logic [ADDR_WIDTH-1:0] address_0,
	input  logic [ADDR_WIDTH-1:0] address_1,
	input  logic [DATA_WIDTH-1:0] data_in_0,
	input  logic [DATA_WIDTH-1:0] data_in_1,
	input  logic                  we_0,
	input  logic                  we_1,
	input  logic                  oe_0,
	input  logic                  oe_1,
	output logic [DATA_WIDTH-1:0] data_out_0,
	output logic [DATA_WIDTH-1:0] data_out_1
);

	// Shared feature storage, contents are undefined until written
	logic [DATA_WIDTH-1:0] mem [MEM_DEPTH];

	// Both ports write independently at the same edge
	always_ff @(posedge clk) begin
		if (we_0)
			mem[address_0] <= data_in_0;
		if (we_1)
			mem[address_1] <= data_in_1;
	end

	// Read data is registered and only moves when its port is enabled
	// so the last fetched pair stays visible
	always_ff @(posedge clk) begin
		if (oe_0)
			data_out_0 <= mem[address_0];
		if (oe_1)
			data_out_1 <= mem[address_1];
	end

	// Two ports hitting one word must agree on what to store there
	a_no_write_clash: assert property (@(posedge clk) disable iff (!reset_N)
		(we_0 && we_1 && address_0 == address_1) |-> data_in_0 == data_in_1);

endmodule

// File: rtl/oflow_pkg.sv
package oflow_pkg;

	// Memory geometry and field widths, all fixed by the memory layout
	localparam int DATA_WIDTH   = 16;
	localparam int ADDR_WIDTH   = 7;
	localparam int MEM_DEPTH    = 128;
	localparam int OFFSET_WIDTH = 7;
	localparam int FRAME_WIDTH  = 8;
	localparam int HIST_WIDTH   = 3;
	localparam int MAX_HIST     = 5;

	// One feature pair as written by the front end, two words at two offsets
	typedef struct packed {
		logic [DATA_WIDTH-1:0]   data_0;
		logic [DATA_WIDTH-1:0]   data_1;
		logic [OFFSET_WIDTH-1:0] offset_0;
		logic [OFFSET_WIDTH-1:0] offset_1;
	} feature_pair_t;

	// Request to the shared buffer, the data words are ignored on reads
	typedef struct packed {
		logic                   we;
		logic [FRAME_WIDTH-1:0] frame_sel;
		feature_pair_t          pair;
	} mem_req_t;

	// Which peer wins the next cycle in which both of them request
	typedef enum logic {
		PREFER_WRITER,
		PREFER_READER
	} arb_state_t;

	// Size of one region, floor(128 / N), for N from 1 to MAX_HIST
	function automatic logic [ADDR_WIDTH:0] region_size(input logic [HIST_WIDTH-1:0] hist);
		case (hist)
			3'd2: region_size = (ADDR_WIDTH+1)'(MEM_DEPTH / 2);
			3'd3: region_size = (ADDR_WIDTH+1)'(MEM_DEPTH / 3);
			3'd4: region_size = (ADDR_WIDTH+1)'(MEM_DEPTH / 4);
			3'd5: region_size = (ADDR_WIDTH+1)'(MEM_DEPTH / 5);
			default: region_size = (ADDR_WIDTH+1)'(MEM_DEPTH);
		endcase
	endfunction

endpackage
